// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary -j 0
TOP      = tb_vis_buffer
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# build, run, then decide on the log contents
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/vis_buffer.sv ====
module vis_buffer (
   input  logic                clk_i,
   input  logic                rst_i,

   // correlator bus, this block is the master
   output logic                cyc_o,
   output logic                stb_o,
   output vis_pkg::vis_addr_t  adr_o,
   input  logic                ack_i,
   input  vis_pkg::vis_word_u  dat_i,

   // byte slave port towards the spi bridge, read only
   input  logic                stb_i,
   input  vis_pkg::byte_addr_t adr_i,
   output logic                ack_o,
   output logic [7:0]          byt_o,

   // status
   input  logic                switching_i,   // correlators swapped banks
   output logic                available_o,   // full window in the sram
   output vis_pkg::vis_word_u  checksum_o     // xor of every fetched word
);

   import vis_pkg::*;

   // prefetcher to sram write path
   logic      wr_en;
   vis_addr_t wr_adr;
   vis_word_u wr_dat;

   vis_word_u checksum_q;

   // ----------------------------------------------------------------------
   // prefetch, correlators -> sram after each bank switch
   // ----------------------------------------------------------------------

   vis_prefetch prefetch0 (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .begin_i  (switching_i),
      .ready_o  (available_o),
      .cyc_o    (cyc_o),      // correlator side
      .stb_o    (stb_o),
      .adr_o    (adr_o),
      .ack_i    (ack_i),
      .dat_i    (dat_i),
      .wr_en_o  (wr_en),      // sram side
      .wr_adr_o (wr_adr),
      .wr_dat_o (wr_dat)
   );

   // ----------------------------------------------------------------------
   // window buffer, word in and bytes out
   // ----------------------------------------------------------------------

   vis_sram sram0 (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wr_en_i  (wr_en),
      .wr_adr_i (wr_adr),
      .wr_dat_i (wr_dat),
      .rd_stb_i (stb_i),      // byte port maps directly onto the read side
      .rd_adr_i (adr_i),
      .rd_ack_o (ack_o),
      .rd_byt_o (byt_o)
   );

   // running checksum, only reset clears it so it spans windows
   always_ff @(posedge clk_i) begin
      if (rst_i)
         checksum_q <= '0;
      else if (stb_o && ack_i)
         checksum_q.word <= checksum_q.word ^ dat_i.word;   // one word per ack
   end

   assign checksum_o = checksum_q;

endmodule

// ==== hw/vis_defs.svh ====
`ifndef VIS_DEFS_SVH
`define VIS_DEFS_SVH

// ----------------------------------------------------------------------
// visibility window geometry
// ----------------------------------------------------------------------

// width of one correlator visibility word
`define VIS_WIDTH 24

// words per window, read out after every bank switch
`define VIS_COUNT 48

// word address bits, must cover VIS_COUNT
`define VIS_ABITS 6

// byte lanes per word on the byte port, lane 3 reads back as zero
`define VIS_LANES 3

`endif

// ==== hw/vis_pkg.sv ====
`include "vis_defs.svh"

package vis_pkg;

   // ----------------------------------------------------------------------
   // shared types for the visibilities buffer
   // ----------------------------------------------------------------------

   // one visibility word, two views of the same 24 bits
   typedef union packed {
      logic [`VIS_WIDTH-1:0]       word;   // prefetcher and checksum view
      logic [`VIS_LANES-1:0][7:0]  lanes;  // byte port view, lane 0 = lsb
   } vis_word_u;

   // word address on the correlator bus and into the sram
   typedef logic [`VIS_ABITS-1:0] vis_addr_t;

   // byte port address: {word, lane}
   typedef logic [`VIS_ABITS+1:0] byte_addr_t;

   // lane select, low two bits of a byte address
   typedef logic [1:0] lane_t;

endpackage

// ==== hw/vis_prefetch.sv ====
`include "vis_defs.svh"

module vis_prefetch (
   input  logic              clk_i,
   input  logic              rst_i,

   // bank switch start and window-complete flag
   input  logic              begin_i,
   output logic              ready_o,

   // correlator bus master doing single reads
   output logic              cyc_o,
   output logic              stb_o,
   output vis_pkg::vis_addr_t adr_o,
   input  logic              ack_i,
   input  vis_pkg::vis_word_u dat_i,

   // sram write side
   output logic              wr_en_o,
   output vis_pkg::vis_addr_t wr_adr_o,
   output vis_pkg::vis_word_u wr_dat_o
);

   import vis_pkg::*;

   // ----------------------------------------------------------------------
   // controller state
   // ----------------------------------------------------------------------

   typedef enum logic {
      ST_IDLE,    // waiting for a bank switch
      ST_FETCH    // walking the window, one read per address
   } state_t;

   localparam vis_addr_t LAST_ADR = vis_addr_t'(`VIS_COUNT - 1);

   state_t    state_q;
   vis_addr_t adr_q;     // address of the request in flight
   logic      ready_q;   // complete window held in the sram
   logic      accept;    // request acknowledged this cycle
   logic      last;      // the acknowledged word ends the window

   // ack only counts while the request is up
   assign accept = stb_o && ack_i;
   assign last   = (adr_q == LAST_ADR);

   // ----------------------------------------------------------------------
   // fsm and address counter
   // ----------------------------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
         adr_q   <= '0;
         ready_q <= 1'b0;   // nothing fetched yet
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (begin_i) begin
                  state_q <= ST_FETCH;
                  adr_q   <= '0;     // windows always start at word 0
                  ready_q <= 1'b0;   // old window is being overwritten
               end
            end
            ST_FETCH: begin
               // begin_i is ignored here so a fetch is never restarted
               if (accept) begin
                  if (last) begin
                     state_q <= ST_IDLE;
                     adr_q   <= '0;
                     ready_q <= 1'b1;   // last word lands in the sram now
                  end else begin
                     adr_q <= adr_q + vis_addr_t'(1);   // next request follows at once
                  end
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // bus and sram outputs
   // ----------------------------------------------------------------------

   // request held for the whole fetch with the address moving only on ack
   assign cyc_o = (state_q == ST_FETCH);
   assign stb_o = (state_q == ST_FETCH);
   assign adr_o = adr_q;

   assign ready_o = ready_q;

   // acknowledged word goes straight into the sram in the same cycle
   assign wr_en_o  = accept;
   assign wr_adr_o = adr_q;
   assign wr_dat_o = dat_i;

endmodule

// ==== hw/vis_sram.sv ====
`include "vis_defs.svh"

module vis_sram (
   input  logic                clk_i,
   input  logic                rst_i,

   // word write port, filled by the prefetcher
   input  logic                wr_en_i,
   input  vis_pkg::vis_addr_t  wr_adr_i,
   input  vis_pkg::vis_word_u  wr_dat_i,

   // byte read port, driven from the spi side
   input  logic                rd_stb_i,
   input  vis_pkg::byte_addr_t rd_adr_i,
   output logic                rd_ack_o,
   output logic [7:0]          rd_byt_o
);

   import vis_pkg::*;

   // ----------------------------------------------------------------------
   // storage
   // ----------------------------------------------------------------------

   vis_word_u mem [0:`VIS_COUNT-1];   // one window of visibilities

   vis_addr_t  rd_word_adr;   // word part of the byte address
   lane_t      rd_lane;       // lane part
   logic       rd_pad;        // lane beyond the word, reads as zero
   logic [7:0] rd_byt_q;
   logic       rd_ack_q;

   assign rd_word_adr = rd_adr_i[`VIS_ABITS+1:2];
   assign rd_lane     = rd_adr_i[1:0];
   assign rd_pad      = (rd_lane >= lane_t'(`VIS_LANES));

   // write port, no handshake, one word per cycle at most
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_adr_i] <= wr_dat_i;
      end
   end

   // ----------------------------------------------------------------------
   // byte read port
   // ----------------------------------------------------------------------

   // byte is registered on the strobe and held until the next one
   always_ff @(posedge clk_i) begin
      if (rd_stb_i) begin
         if (rd_pad)
            rd_byt_q <= 8'h00;                         // lane 3 padding
         else
            rd_byt_q <= mem[rd_word_adr].lanes[rd_lane];
      end
   end

   // fixed one-cycle ack, no back-pressure on this port
   always_ff @(posedge clk_i) begin
      if (rst_i)
         rd_ack_q <= 1'b0;
      else
         rd_ack_q <= rd_stb_i;
   end

   assign rd_ack_o = rd_ack_q;
   assign rd_byt_o = rd_byt_q;

endmodule

// ==== testbench/tb_vis_buffer.sv ====
`include "vis_defs.svh"

module tb_vis_buffer;

   import vis_pkg::*;

   // worst case per word is 3 wait cycles plus the ack cycle
   localparam int FETCH_MAX   = `VIS_COUNT * 4;
   localparam int READ_MAX    = 4 * `VIS_COUNT * 2;     // strobe cycle + idle cycle
   localparam int CYCLE_LIMIT = 4 * (3 * FETCH_MAX + 2 * READ_MAX);
   localparam int MID_SWITCH  = `VIS_COUNT / 2;          // well inside any fetch

   logic       clk_i;
   logic       rst_i;
   logic       cyc_o;
   logic       stb_o;
   vis_addr_t  adr_o;
   logic       ack_i;
   vis_word_u  dat_i;
   logic       stb_i;
   byte_addr_t adr_i;
   logic       ack_o;
   logic [7:0] byt_o;
   logic       switching_i;
   logic       available_o;
   vis_word_u  checksum_o;

   vis_word_u   window [0:`VIS_COUNT-1];   // data the correlators serve
   vis_word_u   exp_sum;                   // xor of every window served so far
   vis_addr_t   acked [$];                 // addresses acknowledged in this fetch
   logic [15:0] lfsr_q;
   int          corr_wait;                 // cycles left before the next ack
   logic        corr_armed;                // delay drawn for the current request
   int          cycles = 0;
   int          test_errs;
   int          pass_cnt;
   int          fail_cnt;

   vis_buffer dut0 (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cyc_o       (cyc_o),
      .stb_o       (stb_o),
      .adr_o       (adr_o),
      .ack_i       (ack_i),
      .dat_i       (dat_i),
      .stb_i       (stb_i),
      .adr_i       (adr_i),
      .ack_o       (ack_o),
      .byt_o       (byt_o),
      .switching_i (switching_i),
      .available_o (available_o),
      .checksum_o  (checksum_o)
   );

   always #50 clk_i = ~clk_i;

   // watchdog bounding every wait loop below
   always @(negedge clk_i) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, a fetch or readout never finished", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // ----------------------------------------------------------------------
   // random source with taps x^16 + x^14 + x^13 + x^11 + 1
   // ----------------------------------------------------------------------

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] draw_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);   // one step per bit taken
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // expected byte with lane 0 as the lsb and lane 3 as zero
   function automatic logic [7:0] expect_byte(input byte_addr_t a);
      logic [`VIS_WIDTH-1:0] w;
      int                    lane;
      w    = window[a[`VIS_ABITS+1:2]].word;
      lane = int'(a[1:0]);
      if (lane >= `VIS_LANES)
         return 8'h00;
      return 8'(w >> (8 * lane));
   endfunction

   // ----------------------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------------------

   task automatic check_word(input string name, input string what,
                             input vis_word_u exp, input vis_word_u act);
      if (act !== exp) begin
         $display("** Error [%s] %s: expected %h, actual %h", name, what, exp.word, act.word);
         test_errs++;
      end
   endtask

   task automatic check_byte(input string name, input string what,
                             input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("** Error [%s] %s: expected %h, actual %h", name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_bit(input string name, input string what,
                            input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error [%s] %s: expected %b, actual %b", name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_addr(input string name, input string what,
                             input vis_addr_t exp, input vis_addr_t act);
      if (act !== exp) begin
         $display("** Error [%s] %s: expected %0d, actual %0d", name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_count(input string name, input string what,
                              input int exp, input int act);
      if (act != exp) begin
         $display("** Error [%s] %s: expected %0d, actual %0d", name, what, exp, act);
         test_errs++;
      end
   endtask

   // ----------------------------------------------------------------------
   // cycle stepping and correlator model
   // ----------------------------------------------------------------------

   // outputs are settled at the falling edge and inputs change here
   task automatic next_cycle();
      logic [31:0] v;
      @(negedge clk_i);
      ack_i = 1'b0;                          // any earlier ack was taken at the rising edge
      if (stb_o && !rst_i) begin
         if (!corr_armed) begin
            v          = draw_bits(2);       // 0 to 3 wait cycles
            corr_wait  = int'(v[1:0]);
            corr_armed = 1'b1;
         end
         if (corr_wait == 0) begin
            ack_i      = 1'b1;
            dat_i      = window[adr_o];
            acked.push_back(adr_o);
            corr_armed = 1'b0;
         end else begin
            corr_wait--;
         end
      end
   endtask

   task automatic fill_window();
      logic [31:0] v;
      for (int i = 0; i < `VIS_COUNT; i++) begin
         v              = draw_bits(`VIS_WIDTH);
         window[i].word = v[`VIS_WIDTH-1:0];
         exp_sum.word   = exp_sum.word ^ window[i].word;   // every word gets acked once
      end
   endtask

   task automatic run_fetch(input string name, input logic inject);
      int n;
      fill_window();
      acked.delete();
      switching_i = 1'b1;
      next_cycle();
      switching_i = 1'b0;
      check_bit(name, "available_o after switch", 1'b0, available_o);
      check_bit(name, "cyc_o after switch", 1'b1, cyc_o);
      check_bit(name, "stb_o after switch", 1'b1, stb_o);
      check_addr(name, "first address", '0, adr_o);
      n = 0;
      while (!available_o) begin
         next_cycle();
         n++;
         switching_i = inject && (n == MID_SWITCH);   // stray switch mid fetch
         if (switching_i)
            check_bit(name, "stb_o at stray switch", 1'b1, stb_o);
      end
      switching_i = 1'b0;
      check_bit(name, "cyc_o after fetch", 1'b0, cyc_o);
      check_bit(name, "stb_o after fetch", 1'b0, stb_o);
      check_count(name, "acknowledged requests", `VIS_COUNT, acked.size());
      for (int i = 0; i < acked.size() && i < `VIS_COUNT; i++)
         check_addr(name, $sformatf("request %0d address", i), vis_addr_t'(i), acked[i]);
   endtask

   task automatic read_window(input string name);
      for (int a = 0; a < 4 * `VIS_COUNT; a++) begin
         stb_i = 1'b1;
         adr_i = byte_addr_t'(a);
         next_cycle();
         stb_i = 1'b0;
         check_bit(name, "ack_o one cycle after stb_i", 1'b1, ack_o);
         check_byte(name, $sformatf("byte %0d", a), expect_byte(adr_i), byt_o);
         next_cycle();
         check_bit(name, "ack_o in the following cycle", 1'b0, ack_o);
      end
   endtask

   // ----------------------------------------------------------------------
   // tests
   // ----------------------------------------------------------------------

   task automatic finish_test(input string name);
      if (test_errs == 0) begin
         pass_cnt++;
         $display("test %-16s passed", name);
      end else begin
         fail_cnt++;
         $display("test %-16s failed with %0d errors", name, test_errs);
      end
      test_errs = 0;
   endtask

   task automatic test_reset();
      check_bit("reset_state", "cyc_o", 1'b0, cyc_o);
      check_bit("reset_state", "stb_o", 1'b0, stb_o);
      check_bit("reset_state", "ack_o", 1'b0, ack_o);
      check_bit("reset_state", "available_o", 1'b0, available_o);
      check_word("reset_state", "checksum_o", '0, checksum_o);
      finish_test("reset_state");
   endtask

   task automatic test_fetch();
      run_fetch("fetch", 1'b0);
      finish_test("fetch");
   endtask

   task automatic test_readout();
      read_window("readout");
      finish_test("readout");
   endtask

   task automatic test_checksum();
      check_word("checksum", "checksum_o", exp_sum, checksum_o);   // held through readout
      finish_test("checksum");
   endtask

   task automatic test_second_window();
      run_fetch("second_window", 1'b0);
      read_window("second_window");
      check_word("second_window", "checksum_o", exp_sum, checksum_o);
      finish_test("second_window");
   endtask

   task automatic test_switch_ignored();
      run_fetch("switch_ignored", 1'b1);
      check_word("switch_ignored", "checksum_o", exp_sum, checksum_o);
      finish_test("switch_ignored");
   endtask

   initial begin
      clk_i       = 1'b0;
      rst_i       = 1'b1;
      ack_i       = 1'b0;
      dat_i       = '0;
      stb_i       = 1'b0;
      adr_i       = '0;
      switching_i = 1'b0;
      lfsr_q      = 16'd14169;
      corr_wait   = 0;
      corr_armed  = 1'b0;
      exp_sum     = '0;
      test_errs   = 0;
      pass_cnt    = 0;
      fail_cnt    = 0;
      repeat (3) @(negedge clk_i);   // three rising edges under reset
      rst_i = 1'b0;

      test_reset();
      test_fetch();
      test_readout();
      test_checksum();
      test_second_window();
      test_switch_ignored();

      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/vis_pkg.sv
hw/vis_prefetch.sv
hw/vis_sram.sv
hw/vis_buffer.sv
testbench/tb_vis_buffer.sv
